// File: pt_shim_testdata.txt
# In: c0v c0addr c0md c1ctl c1addr c1md c1data r0v r0md r0data r1v r1md hflow rde rdaddr rdtag wre wraddr wrtag wrdata
# Exp: c0v c0addr c0md c1ctl c1addr c1md c1data rxvalid aflow rde rdtag rddata wdone rdy err
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0 0 3 0
1 100 0012 c 200 0034 1111 1 0012 abcd 1 0034 2 0 0 0 0 0 0 0  1 100 0012 c 200 0034 1111 3 2 0 0 0 0 3 0
0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 1 0 0 0 0 3 0
0 0 0 0 0 0 0 0 0 0 0 0 0 1 300 05 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0 0 3 0
1 101 0013 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  1 101 0013 0 0 0 0 0 2 0 0 0 0 1 0
0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 2 0 0 0 0 1 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  1 300 8005 0 0 0 0 0 2 0 0 0 0 1 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0 0 3 0
0 0 0 0 0 0 0 1 8005 cafe 1 0040 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 1 0 1 05 cafe 0 3 0
0 0 0 f 400 0050 a0 0 0 0 0 0 0 0 0 0 1 500 07 77  0 0 0 f 400 0050 a0 0 0 0 0 0 0 3 0
0 0 0 8 400 0050 a1 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 8 400 0050 a1 0 1 0 0 0 0 2 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 1 0 0 0 0 2 0
0 0 0 8 400 0050 a2 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 8 400 0050 a2 0 1 0 0 0 0 2 0
0 0 0 8 400 0050 a3 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 8 400 0050 a3 0 1 0 0 0 0 2 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 c 500 8007 77 0 1 0 0 0 0 2 0
0 0 0 0 0 0 0 1 0012 1234 1 8007 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 2 0 0 0 0 1 3 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 600 09 99  0 0 0 0 0 0 0 0 0 0 0 0 0 3 0
0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 1 0 0 0 0 2 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 c 600 8009 99 0 1 0 0 0 0 2 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0 0 3 0
1 700 8001 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  1 700 8001 0 0 0 0 0 0 0 0 0 0 3 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 3 0 0 0 0 3 1
0 0 0 0 0 0 0 0 0 0 0 0 0 1 310 0a 0 0 0 0  0 0 0 0 0 0 0 0 3 0 0 0 0 3 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  1 310 800a 0 0 0 0 0 3 0 0 0 0 1 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 3 0 0 0 0 3 1
0 0 0 0 0 0 0 1 800a beef 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 3 1 0a beef 0 3 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 3 0 0 0 0 3 1

// File: pt_shim.f
shim_pkg.sv
write_packet_tracker.sv
tag_guard.sv
pt_read_inject.sv
pt_write_inject.sv
rsp_filter.sv
pt_shim_top.sv
tb_pt_shim.sv

// File: run_sim.sh
#!/bin/sh
# Builds the shim testbench with Verilator, runs it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_pt_shim -f pt_shim.f -o sim_pt_shim &&
./obj_dir/sim_pt_shim | tee /dev/stderr | grep -q "Everything OK" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: tb_pt_shim.sv
// Vector-driven testbench for the page-table shim
// Each line of pt_shim_testdata.txt is one clock of stimulus and expected outputs
`timescale 1ns/1ps
`default_nettype none

module tb_pt_shim
    import shim_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_CYCLES   = 1000;
    localparam int NUM_FIELDS   = 35;

    logic       clk;
    logic       reset_n;
    t_c0_tx     afu_c0_tx;
    t_c1_tx     afu_c1_tx;
    t_c0_tx     host_c0_tx;
    t_c1_tx     host_c1_tx;
    t_c0_rx     host_c0_rx;
    t_c1_rx     host_c1_rx;
    t_host_flow host_flow;
    t_c0_rx     afu_c0_rx;
    t_c1_rx     afu_c1_rx;
    t_host_flow afu_flow;
    logic       error;
    t_pt_req    pt_read;
    t_pt_req    pt_write;
    logic       pt_read_rdy;
    logic       pt_write_rdy;
    t_pt_rsp    pt_rsp;

    // Stimulus fields of one vector line, in file order
    logic [63:0] in_c0v, in_c0a, in_c0m;
    logic [63:0] in_c1ctl, in_c1a, in_c1m, in_c1d;
    logic [63:0] in_r0v, in_r0m, in_r0d, in_r1v, in_r1m, in_hf;
    logic [63:0] in_rde, in_rda, in_rdt, in_wre, in_wra, in_wrt, in_wrd;

    // Expected outputs of the same line
    logic [63:0] exp_c0v, exp_c0a, exp_c0m;
    logic [63:0] exp_c1ctl, exp_c1a, exp_c1m, exp_c1d;
    logic [63:0] exp_rxv, exp_af, exp_rde, exp_rdt, exp_rdd, exp_wd, exp_rdy, exp_err;

    int    fd;
    int    field_count;
    int    line_no;
    int    vector_count;
    int    error_count;
    int    bad_line_count;
    bit    done;
    bit    timed_out;
    bit    open_failed;
    string text_line;

    pt_shim_top UUT (
        .clk          (clk),
        .reset_n      (reset_n),
        .afu_c0_tx    (afu_c0_tx),
        .afu_c1_tx    (afu_c1_tx),
        .host_c0_tx   (host_c0_tx),
        .host_c1_tx   (host_c1_tx),
        .host_c0_rx   (host_c0_rx),
        .host_c1_rx   (host_c1_rx),
        .host_flow    (host_flow),
        .afu_c0_rx    (afu_c0_rx),
        .afu_c1_rx    (afu_c1_rx),
        .afu_flow     (afu_flow),
        .error        (error),
        .pt_read      (pt_read),
        .pt_write     (pt_write),
        .pt_read_rdy  (pt_read_rdy),
        .pt_write_rdy (pt_write_rdy),
        .pt_rsp       (pt_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ======================================================================
    // Stimulus and checking
    // ======================================================================

    // Quiet bus on every input, used until the first vector
    task automatic drive_idle();
        afu_c0_tx  = '0;
        afu_c1_tx  = '0;
        host_c0_rx = '0;
        host_c1_rx = '0;
        host_flow  = '0;
        pt_read    = '0;
        pt_write   = '0;
    endtask

    // Control nibble of channel 1 is valid, sop, then the 2-bit line code
    task automatic apply_vector();
        afu_c0_tx.valid      = in_c0v[0];
        afu_c0_tx.addr       = in_c0a[ADDR_WIDTH-1:0];
        afu_c0_tx.mdata      = in_c0m[MDATA_WIDTH-1:0];
        afu_c1_tx.valid      = in_c1ctl[3];
        afu_c1_tx.sop        = in_c1ctl[2];
        afu_c1_tx.cl_len     = in_c1ctl[1:0];
        afu_c1_tx.addr       = in_c1a[ADDR_WIDTH-1:0];
        afu_c1_tx.mdata      = in_c1m[MDATA_WIDTH-1:0];
        afu_c1_tx.data       = in_c1d[DATA_WIDTH-1:0];
        host_c0_rx.rsp_valid = in_r0v[0];
        host_c0_rx.mdata     = in_r0m[MDATA_WIDTH-1:0];
        host_c0_rx.data      = in_r0d[DATA_WIDTH-1:0];
        host_c1_rx.rsp_valid = in_r1v[0];
        host_c1_rx.mdata     = in_r1m[MDATA_WIDTH-1:0];
        // Bit 1 is channel 0 and bit 0 is channel 1, as in the packed struct
        host_flow            = in_hf[1:0];
        pt_read.en           = in_rde[0];
        pt_read.addr         = in_rda[ADDR_WIDTH-1:0];
        pt_read.tag          = in_rdt[PT_TAG_WIDTH-1:0];
        pt_read.data         = '0;
        pt_write.en          = in_wre[0];
        pt_write.addr        = in_wra[ADDR_WIDTH-1:0];
        pt_write.tag         = in_wrt[PT_TAG_WIDTH-1:0];
        pt_write.data        = in_wrd[DATA_WIDTH-1:0];
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] expected);
        $display("[ERROR] %0t: vector line %0d, %s is %0h, expected %0h",
                 $time, line_no, what, got, expected);
        error_count++;
    endtask

    // Address and payload only matter on a valid beat or response
    task automatic compare_outputs();
        if (host_c0_tx.valid !== exp_c0v[0])
            report_mismatch("host_c0_tx.valid", 64'(host_c0_tx.valid), exp_c0v);
        if (exp_c0v[0])
        begin
            if (host_c0_tx.addr !== exp_c0a[ADDR_WIDTH-1:0])
                report_mismatch("host_c0_tx.addr", 64'(host_c0_tx.addr), exp_c0a);
            if (host_c0_tx.mdata !== exp_c0m[MDATA_WIDTH-1:0])
                report_mismatch("host_c0_tx.mdata", 64'(host_c0_tx.mdata), exp_c0m);
        end
        if (host_c1_tx.valid !== exp_c1ctl[3])
            report_mismatch("host_c1_tx.valid", 64'(host_c1_tx.valid), 64'(exp_c1ctl[3]));
        if (exp_c1ctl[3])
        begin
            if ({host_c1_tx.valid, host_c1_tx.sop, host_c1_tx.cl_len} !== exp_c1ctl[3:0])
                report_mismatch("host_c1_tx control",
                    64'({host_c1_tx.valid, host_c1_tx.sop, host_c1_tx.cl_len}), exp_c1ctl);
            if (host_c1_tx.addr !== exp_c1a[ADDR_WIDTH-1:0])
                report_mismatch("host_c1_tx.addr", 64'(host_c1_tx.addr), exp_c1a);
            if (host_c1_tx.mdata !== exp_c1m[MDATA_WIDTH-1:0])
                report_mismatch("host_c1_tx.mdata", 64'(host_c1_tx.mdata), exp_c1m);
            if (host_c1_tx.data !== exp_c1d[DATA_WIDTH-1:0])
                report_mismatch("host_c1_tx.data", 64'(host_c1_tx.data), exp_c1d);
        end
        if ({afu_c0_rx.rsp_valid, afu_c1_rx.rsp_valid} !== exp_rxv[1:0])
            report_mismatch("AFU response valids",
                64'({afu_c0_rx.rsp_valid, afu_c1_rx.rsp_valid}), exp_rxv);
        // A response that reaches the AFU carries the host's mdata and data unchanged
        if (exp_rxv[1])
        begin
            if (afu_c0_rx.mdata !== in_r0m[MDATA_WIDTH-1:0])
                report_mismatch("afu_c0_rx.mdata", 64'(afu_c0_rx.mdata), in_r0m);
            if (afu_c0_rx.data !== in_r0d[DATA_WIDTH-1:0])
                report_mismatch("afu_c0_rx.data", 64'(afu_c0_rx.data), in_r0d);
        end
        if (exp_rxv[0])
        begin
            if (afu_c1_rx.mdata !== in_r1m[MDATA_WIDTH-1:0])
                report_mismatch("afu_c1_rx.mdata", 64'(afu_c1_rx.mdata), in_r1m);
        end
        if (afu_flow !== exp_af[1:0])
            report_mismatch("afu_flow", 64'(afu_flow), exp_af);
        if (pt_rsp.read_en !== exp_rde[0])
            report_mismatch("pt_rsp.read_en", 64'(pt_rsp.read_en), exp_rde);
        if (exp_rde[0])
        begin
            if (pt_rsp.read_tag !== exp_rdt[PT_TAG_WIDTH-1:0])
                report_mismatch("pt_rsp.read_tag", 64'(pt_rsp.read_tag), exp_rdt);
            if (pt_rsp.read_data !== exp_rdd[DATA_WIDTH-1:0])
                report_mismatch("pt_rsp.read_data", 64'(pt_rsp.read_data), exp_rdd);
        end
        if (pt_rsp.write_done !== exp_wd[0])
            report_mismatch("pt_rsp.write_done", 64'(pt_rsp.write_done), exp_wd);
        if ({pt_read_rdy, pt_write_rdy} !== exp_rdy[1:0])
            report_mismatch("read and write rdy", 64'({pt_read_rdy, pt_write_rdy}), exp_rdy);
        if (error !== exp_err[0])
            report_mismatch("error", 64'(error), exp_err);
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial
    begin
        line_no        = 0;
        vector_count   = 0;
        error_count    = 0;
        bad_line_count = 0;
        done           = 1'b0;
        timed_out      = 1'b0;
        open_failed    = 1'b0;
        drive_idle();
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;

        fd = $fopen("pt_shim_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the vector file pt_shim_testdata.txt");
            open_failed = 1'b1;
        end
        else
        begin
            // Comment and blank lines match no field and are skipped
            while (!done && vector_count < MAX_CYCLES)
            begin
                if ($fgets(text_line, fd) == 0)
                begin
                    done = 1'b1;
                end
                else
                begin
                    line_no++;
                    field_count = $sscanf(text_line,
                        "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                        in_c0v, in_c0a, in_c0m, in_c1ctl, in_c1a, in_c1m, in_c1d,
                        in_r0v, in_r0m, in_r0d, in_r1v, in_r1m, in_hf,
                        in_rde, in_rda, in_rdt, in_wre, in_wra, in_wrt, in_wrd,
                        exp_c0v, exp_c0a, exp_c0m, exp_c1ctl, exp_c1a, exp_c1m, exp_c1d,
                        exp_rxv, exp_af, exp_rde, exp_rdt, exp_rdd, exp_wd, exp_rdy,
                        exp_err);
                    if (field_count == NUM_FIELDS)
                    begin
                        @(negedge clk);
                        apply_vector();
                        // Sample just ahead of the rising edge that consumes the vector
                        #(CLK_PERIOD / 2 - 1);
                        compare_outputs();
                        vector_count++;
                    end
                    else if (field_count > 0)
                    begin
                        $display("Vector line %0d holds %0d fields where %0d are needed",
                                 line_no, field_count, NUM_FIELDS);
                        bad_line_count++;
                    end
                end
            end
            if (!done)
            begin
                $display("Timeout: the vector file still had lines after %0d cycles",
                         MAX_CYCLES);
                timed_out = 1'b1;
            end
            $fclose(fd);
        end

        $display("Vectors: %0d, mismatches: %0d, bad lines: %0d",
                 vector_count, error_count, bad_line_count);
        if (error_count == 0 && bad_line_count == 0 && !timed_out && !open_failed &&
            vector_count > 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: pt_shim_top.sv
// Page-table shim placed between the AFU and the host memory channels
// Set the mdata tag mask and value here; every block receives the same pair
`timescale 1ns/1ps
`default_nettype none

module pt_shim_top
    import shim_pkg::*;
#(
    parameter t_mdata MDATA_TAG_MASK  = t_mdata'(1) << (MDATA_WIDTH - 1),
    parameter t_mdata MDATA_TAG_VALUE = MDATA_TAG_MASK
)
(
    input  wire logic       clk,
    input  wire logic       reset_n,

    // AFU requests and the host side of the request channels
    input  wire t_c0_tx     afu_c0_tx,
    input  wire t_c1_tx     afu_c1_tx,
    output t_c0_tx          host_c0_tx,
    output t_c1_tx          host_c1_tx,

    // Host responses and what the AFU sees of them
    input  wire t_c0_rx     host_c0_rx,
    input  wire t_c1_rx     host_c1_rx,
    input  wire t_host_flow host_flow,
    output t_c0_rx          afu_c0_rx,
    output t_c1_rx          afu_c1_rx,
    output t_host_flow      afu_flow,
    output logic            error,

    // Page-table agent
    input  wire t_pt_req    pt_read,
    input  wire t_pt_req    pt_write,
    output logic            pt_read_rdy,
    output logic            pt_write_rdy,
    output t_pt_rsp         pt_rsp
);

    logic read_pending;
    logic write_pending;

    pt_read_inject #(
        .MDATA_TAG_MASK  (MDATA_TAG_MASK),
        .MDATA_TAG_VALUE (MDATA_TAG_VALUE)
    ) u_read_inject (
        .clk          (clk),
        .reset_n      (reset_n),
        .pt_read      (pt_read),
        .pt_read_rdy  (pt_read_rdy),
        .read_pending (read_pending),
        .afu_c0_tx    (afu_c0_tx),
        .host_flow    (host_flow),
        .host_c0_tx   (host_c0_tx)
    );

    pt_write_inject #(
        .MDATA_TAG_MASK  (MDATA_TAG_MASK),
        .MDATA_TAG_VALUE (MDATA_TAG_VALUE)
    ) u_write_inject (
        .clk           (clk),
        .reset_n       (reset_n),
        .pt_write      (pt_write),
        .pt_write_rdy  (pt_write_rdy),
        .write_pending (write_pending),
        .afu_c1_tx     (afu_c1_tx),
        .host_flow     (host_flow),
        .host_c1_tx    (host_c1_tx)
    );

    // Guards the AFU side, not the injected traffic
    tag_guard #(
        .MDATA_TAG_MASK  (MDATA_TAG_MASK),
        .MDATA_TAG_VALUE (MDATA_TAG_VALUE)
    ) u_tag_guard (
        .clk       (clk),
        .reset_n   (reset_n),
        .afu_c0_tx (afu_c0_tx),
        .afu_c1_tx (afu_c1_tx),
        .error     (error)
    );

    rsp_filter #(
        .MDATA_TAG_MASK  (MDATA_TAG_MASK),
        .MDATA_TAG_VALUE (MDATA_TAG_VALUE)
    ) u_rsp_filter (
        .host_c0_rx    (host_c0_rx),
        .host_c1_rx    (host_c1_rx),
        .host_flow     (host_flow),
        .read_pending  (read_pending),
        .write_pending (write_pending),
        .error         (error),
        .afu_c0_rx     (afu_c0_rx),
        .afu_c1_rx     (afu_c1_rx),
        .afu_flow      (afu_flow),
        .pt_rsp        (pt_rsp)
    );

endmodule

`default_nettype wire

// File: rsp_filter.sv
// Routes host responses to the page-table agent or to the AFU by mdata tag
// Also forces the AFU almost-full flags while the shim needs the channels
`timescale 1ns/1ps
`default_nettype none

module rsp_filter
    import shim_pkg::*;
#(
    parameter t_mdata MDATA_TAG_MASK  = t_mdata'(1) << (MDATA_WIDTH - 1),
    parameter t_mdata MDATA_TAG_VALUE = MDATA_TAG_MASK
)
(
    input  wire t_c0_rx     host_c0_rx,
    input  wire t_c1_rx     host_c1_rx,
    input  wire t_host_flow host_flow,
    input  wire logic       read_pending,
    input  wire logic       write_pending,
    input  wire logic       error,
    output t_c0_rx          afu_c0_rx,
    output t_c1_rx          afu_c1_rx,
    output t_host_flow      afu_flow,
    output t_pt_rsp         pt_rsp
);

    logic        is_pt_c0;
    logic        is_pt_c1;
    t_mdata_view c0_view;

    // Responses carrying the shim tag belong to the agent
    assign is_pt_c0 = ((host_c0_rx.mdata & MDATA_TAG_MASK) == MDATA_TAG_VALUE);
    assign is_pt_c1 = ((host_c1_rx.mdata & MDATA_TAG_MASK) == MDATA_TAG_VALUE);

    assign c0_view.afu = host_c0_rx.mdata;

    always_comb
    begin
        pt_rsp.read_en    = host_c0_rx.rsp_valid && is_pt_c0;
        pt_rsp.read_tag   = c0_view.shim.pt_tag;
        pt_rsp.read_data  = host_c0_rx.data;
        pt_rsp.write_done = host_c1_rx.rsp_valid && is_pt_c1;
    end

    always_comb
    begin
        afu_c0_rx = host_c0_rx;
        afu_c1_rx = host_c1_rx;

        // Hide the shim's own traffic from the AFU
        if (is_pt_c0)
        begin
            afu_c0_rx.rsp_valid = 1'b0;
        end

        if (is_pt_c1)
        begin
            afu_c1_rx.rsp_valid = 1'b0;
        end

        // Hold the AFU off while a request waits for a slot, or for good after an error
        afu_flow.c0_alm_full = host_flow.c0_alm_full || read_pending || error;
        afu_flow.c1_alm_full = host_flow.c1_alm_full || write_pending || error;
    end

endmodule

`default_nettype wire

// File: pt_write_inject.sv
// Holds one page-table write and merges it into the AFU write channel
// The write is a single-line packet and never splits an AFU packet
`timescale 1ns/1ps
`default_nettype none

module pt_write_inject
    import shim_pkg::*;
#(
    parameter t_mdata MDATA_TAG_MASK  = t_mdata'(1) << (MDATA_WIDTH - 1),
    parameter t_mdata MDATA_TAG_VALUE = MDATA_TAG_MASK
)
(
    input  wire logic       clk,
    input  wire logic       reset_n,
    input  wire t_pt_req    pt_write,
    output logic            pt_write_rdy,
    output logic            write_pending,
    input  wire t_c1_tx     afu_c1_tx,
    input  wire t_host_flow host_flow,
    output t_c1_tx          host_c1_tx
);

    logic    pending;
    logic    emit;
    logic    packet_active;
    t_addr   req_addr;
    t_pt_tag req_tag;
    t_data   req_data;

    // ======================================================================
    // Request holding
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            pending <= 1'b0;
        end
        else
        begin
            pending <= (pending ^ emit) || pt_write.en;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pt_write.en)
        begin
            req_addr <= pt_write.addr;
            req_tag  <= pt_write.tag;
            req_data <= pt_write.data;
        end
    end

    // ======================================================================
    // Merge into channel 1
    // ======================================================================

    // Beats of an AFU packet must reach the host back to back
    write_packet_tracker u_packet_tracker (
        .clk           (clk),
        .reset_n       (reset_n),
        .afu_c1_tx     (afu_c1_tx),
        .packet_active (packet_active)
    );

    assign emit = pending && !packet_active && !afu_c1_tx.valid &&
                  !host_flow.c1_alm_full;

    assign pt_write_rdy  = !pending;
    assign write_pending = pending;

    always_comb
    begin
        host_c1_tx = afu_c1_tx;

        if (emit)
        begin
            host_c1_tx.valid  = 1'b1;
            host_c1_tx.sop    = 1'b1;
            host_c1_tx.cl_len = 2'd0;
            host_c1_tx.addr   = req_addr;
            host_c1_tx.mdata  = pt_tagged_mdata(MDATA_TAG_VALUE, MDATA_TAG_MASK, req_tag);
            host_c1_tx.data   = req_data;
        end
    end

    a_no_en_while_pending: assert property (@(posedge clk) disable iff (!reset_n)
        pt_write.en |-> !pending);

endmodule

`default_nettype wire

// File: pt_read_inject.sv
// Holds one page-table read and merges it into the AFU read channel
// The read goes out in a cycle where the AFU is idle and the host has room
`timescale 1ns/1ps
`default_nettype none

module pt_read_inject
    import shim_pkg::*;
#(
    parameter t_mdata MDATA_TAG_MASK  = t_mdata'(1) << (MDATA_WIDTH - 1),
    parameter t_mdata MDATA_TAG_VALUE = MDATA_TAG_MASK
)
(
    input  wire logic       clk,
    input  wire logic       reset_n,
    input  wire t_pt_req    pt_read,
    output logic            pt_read_rdy,
    output logic            read_pending,
    input  wire t_c0_tx     afu_c0_tx,
    input  wire t_host_flow host_flow,
    output t_c0_tx          host_c0_tx
);

    logic    pending;
    logic    emit;
    t_addr   req_addr;
    t_pt_tag req_tag;

    // Either the held read went out or a new one arrived
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            pending <= 1'b0;
        end
        else
        begin
            pending <= (pending ^ emit) || pt_read.en;
        end
    end

    // Request payload, captured on the strobe
    always_ff @(posedge clk)
    begin
        if (pt_read.en)
        begin
            req_addr <= pt_read.addr;
            req_tag  <= pt_read.tag;
        end
    end

    // Use a slot the AFU leaves free, and only while the host has room
    assign emit = pending && !afu_c0_tx.valid && !host_flow.c0_alm_full;

    assign pt_read_rdy  = !pending;
    assign read_pending = pending;

    always_comb
    begin
        host_c0_tx = afu_c0_tx;

        if (emit)
        begin
            host_c0_tx.valid = 1'b1;
            host_c0_tx.addr  = req_addr;
            host_c0_tx.mdata = pt_tagged_mdata(MDATA_TAG_VALUE, MDATA_TAG_MASK, req_tag);
        end
    end

    // The agent waits for rdy, so a strobe never lands on a held read
    a_no_en_while_pending: assert property (@(posedge clk) disable iff (!reset_n)
        pt_read.en |-> !pending);

endmodule

`default_nettype wire

// File: tag_guard.sv
// Watches AFU requests for the reserved mdata tag and raises a sticky error
// The error also fires from reset when the tag value has bits outside the mask
`timescale 1ns/1ps
`default_nettype none

module tag_guard
    import shim_pkg::*;
#(
    parameter t_mdata MDATA_TAG_MASK  = t_mdata'(1) << (MDATA_WIDTH - 1),
    parameter t_mdata MDATA_TAG_VALUE = MDATA_TAG_MASK
)
(
    input  wire logic   clk,
    input  wire logic   reset_n,
    input  wire t_c0_tx afu_c0_tx,
    input  wire t_c1_tx afu_c1_tx,
    output logic        error
);

    localparam logic STATE_RUN     = 1'b0;
    localparam logic STATE_BLOCKED = 1'b1;

    // A tag value with bits outside the mask can never match cleanly
    localparam logic TAG_CFG_BAD = ((MDATA_TAG_VALUE & ~MDATA_TAG_MASK) != '0);

    logic state;
    logic c0_bad;
    logic c1_bad;

    // The AFU must never put the shim's own tag on a request
    assign c0_bad = afu_c0_tx.valid &&
                    ((afu_c0_tx.mdata & MDATA_TAG_MASK) == MDATA_TAG_VALUE);
    assign c1_bad = afu_c1_tx.valid &&
                    ((afu_c1_tx.mdata & MDATA_TAG_MASK) == MDATA_TAG_VALUE);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            // A bad configuration blocks traffic straight out of reset
            state <= TAG_CFG_BAD ? STATE_BLOCKED : STATE_RUN;
        end
        else if (c0_bad || c1_bad)
        begin
            state <= STATE_BLOCKED;
        end
    end

    assign error = (state == STATE_BLOCKED);

endmodule

`default_nettype wire

// File: write_packet_tracker.sv
// Follows multi-line AFU write packets on channel 1
// packet_active is high between the sop beat and the last beat of a packet
`timescale 1ns/1ps
`default_nettype none

module write_packet_tracker
    import shim_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_n,
    input  wire t_c1_tx afu_c1_tx,
    output logic        packet_active
);

    // Beats still to come after the current one
    t_cl_len beats_left;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            beats_left <= '0;
        end
        else if (afu_c1_tx.valid)
        begin
            if (afu_c1_tx.sop)
            begin
                // The line code equals the count of beats after the sop beat
                beats_left <= afu_c1_tx.cl_len;
            end
            else if (beats_left != '0)
            begin
                beats_left <= beats_left - 2'd1;
            end
        end
    end

    assign packet_active = (beats_left != '0);

    // A new packet may only start once the previous one has ended
    a_no_sop_in_packet: assert property (@(posedge clk) disable iff (!reset_n)
        (afu_c1_tx.valid && afu_c1_tx.sop) |-> !packet_active);

endmodule

`default_nettype wire

// File: shim_pkg.sv
// Shared widths, channel structs and the mdata view for the page-table shim
// Every shim module imports this package in its module header
`default_nettype none

package shim_pkg;

    // ======================================================================
    // Widths
    // ======================================================================

    // Line address and data path widths of the host channels
    parameter int ADDR_WIDTH = 32;
    parameter int DATA_WIDTH = 64;

    // Request metadata, echoed back by the host in each response
    parameter int MDATA_WIDTH = 16;

    // Request tag of the page-table agent, carried in the low mdata bits
    parameter int PT_TAG_WIDTH = 8;

    typedef logic [ADDR_WIDTH-1:0]   t_addr;
    typedef logic [DATA_WIDTH-1:0]   t_data;
    typedef logic [MDATA_WIDTH-1:0]  t_mdata;
    typedef logic [PT_TAG_WIDTH-1:0] t_pt_tag;

    // Line count of a write packet. Codes 0, 1 and 3 mean 1, 2 and 4 lines
    typedef logic [1:0] t_cl_len;

    // One mdata word read two ways. The AFU sees a plain word, while the shim
    // splits it into a reserved high byte and the agent's tag
    typedef union packed {
        t_mdata afu;
        struct packed {
            logic [MDATA_WIDTH-PT_TAG_WIDTH-1:0] reserved;
            t_pt_tag                             pt_tag;
        } shim;
    } t_mdata_view;

    // ======================================================================
    // Channel structs
    // ======================================================================

    // Read request, channel 0
    typedef struct packed {
        logic   valid;
        t_addr  addr;
        t_mdata mdata;
    } t_c0_tx;

    // Write request beat, channel 1. Only the sop beat starts a packet
    typedef struct packed {
        logic    valid;
        logic    sop;
        t_cl_len cl_len;
        t_addr   addr;
        t_mdata  mdata;
        t_data   data;
    } t_c1_tx;

    // Read response from the host
    typedef struct packed {
        logic   rsp_valid;
        t_mdata mdata;
        t_data  data;
    } t_c0_rx;

    // Write completion from the host
    typedef struct packed {
        logic   rsp_valid;
        t_mdata mdata;
    } t_c1_rx;

    // Host flow control, one almost-full level per request channel
    typedef struct packed {
        logic c0_alm_full;
        logic c1_alm_full;
    } t_host_flow;

    // Page-table agent request, used for reads and writes alike
    typedef struct packed {
        logic    en;
        t_addr   addr;
        t_pt_tag tag;
        t_data   data;
    } t_pt_req;

    // Responses returned to the page-table agent
    typedef struct packed {
        logic    read_en;
        t_pt_tag read_tag;
        t_data   read_data;
        logic    write_done;
    } t_pt_rsp;

    // Builds the mdata of an injected request. The agent tag only fills
    // bits outside the mask, so the tag value always survives
    function automatic t_mdata pt_tagged_mdata(t_mdata tag_value, t_mdata tag_mask,
                                               t_pt_tag pt_tag);
        t_mdata_view view;
        view.shim.reserved = '0;
        view.shim.pt_tag   = pt_tag;
        return tag_value | (view.afu & ~tag_mask);
    endfunction

endpackage

`default_nettype wire
